/* logic/apuRegPkg.sv */
// Register map, register field layouts and channel configuration of the pulse voice
`default_nettype none

package apuRegPkg;

	////////////////////////////////////////
	// CPU register addresses, low byte only
	localparam logic [7:0] regAddrNr21 = 8'h16; // Duty and length load
	localparam logic [7:0] regAddrNr22 = 8'h17; // Volume envelope
	localparam logic [7:0] regAddrNr23 = 8'h18; // Frequency low byte
	localparam logic [7:0] regAddrNr24 = 8'h19; // Trigger, timed mode, frequency high

	// Duty waveforms over 8 steps, bit n is step n
	// High for 1, 2, 4 and 6 steps
	localparam logic [3:0][7:0] dutyTable = {
		8'b0111_1110, // Duty 3, 75%
		8'b1000_0111, // Duty 2, 50%
		8'b1000_0001, // Duty 1, 25%
		8'b0000_0001  // Duty 0, 12.5%
	};

	////////////////////////////////////////
	// Register field layouts as the CPU writes them
	typedef struct packed {
		logic [1:0] duty;       // Waveform select
		logic [5:0] lengthLoad; // Length is 64 minus this
	} nr21Fields;

	typedef struct packed {
		logic [3:0] initVolume; // Volume loaded on trigger
		logic       envUp;      // 1 steps up, 0 steps down
		logic [2:0] envPeriod;  // Envelope ticks per step, 0 freezes
	} nr22Fields;

	typedef struct packed {
		logic       trigger;   // Restart the channel
		logic       timedMode; // Stop when the length counter expires
		logic [2:0] unused;
		logic [2:0] freqHigh;  // Frequency bits 10..8
	} nr24Fields;

	// Stored channel configuration, fed to both execute blocks
	typedef struct packed {
		logic [1:0]  duty;
		logic [5:0]  lengthLoad;
		logic        timedMode;
		logic [3:0]  initVolume;
		logic        envUp;
		logic [2:0]  envPeriod;
		logic [10:0] frequency;
	} chanConfig;

	// Plain CPU write, valid for the cycle the strobe is high
	typedef struct packed {
		logic       strobe;
		logic [7:0] addr;
		logic [7:0] data;
	} cpuWrite;

endpackage

`default_nettype wire

/* logic/apuTimingPkg.sv */
// Clock dividers, counter bases and tick strobes that pace the pulse voice from the CPU clock
`default_nettype none

package apuTimingPkg;

	////////////////////////////////////////
	// Dividers in iClock cycles, powers of two
	localparam int toneDivider     = 32;    // Frequency timer rate
	localparam int lengthDivider   = 16384; // Length counter rate
	localparam int envelopeDivider = 65536; // Envelope step rate

	// Frame counter wraps at the slowest divider
	localparam int seqWidth = $clog2(envelopeDivider);

	////////////////////////////////////////
	// Counter bases
	localparam logic [11:0] freqTimerBase = 12'd2048; // Step length is base minus frequency
	localparam logic [6:0]  lengthBase    = 7'd64;    // Length count is base minus load

	// Output level at silence, midpoint of the 0..30 range
	localparam logic [4:0] levelCenter = 5'd15;

	// One-cycle tick strobes from the frame sequencer
	typedef struct packed {
		logic toneTick;
		logic lengthTick;
		logic envelopeTick;
	} apuTicks;

endpackage

`default_nettype wire

/* logic/soundRegDecode.sv */
// Register decode, stores CPU byte writes as the channel configuration and pulses trigger
`timescale 1ns/100ps
`default_nettype none

module soundRegDecode (
	input  wire logic                iClock,
	input  wire logic                arstN,
	input  wire apuRegPkg::cpuWrite  cpuBus,        // Write strobe, address, data
	output apuRegPkg::chanConfig     channelConfig, // Stored register fields
	output logic                     trigger        // One cycle after NR24 bit 7 write
);

	apuRegPkg::nr21Fields nr21; // Field views of the write data
	apuRegPkg::nr22Fields nr22;
	apuRegPkg::nr24Fields nr24;
	logic wrNr21, wrNr22, wrNr23, wrNr24; // Address hits with strobe

	assign nr21 = cpuBus.data;
	assign nr22 = cpuBus.data;
	assign nr24 = cpuBus.data;

	assign wrNr21 = cpuBus.strobe && (cpuBus.addr == apuRegPkg::regAddrNr21);
	assign wrNr22 = cpuBus.strobe && (cpuBus.addr == apuRegPkg::regAddrNr22);
	assign wrNr23 = cpuBus.strobe && (cpuBus.addr == apuRegPkg::regAddrNr23);
	assign wrNr24 = cpuBus.strobe && (cpuBus.addr == apuRegPkg::regAddrNr24);

	////////////////////////////////////////
	// Register fields, other addresses fall through
	always_ff @(posedge iClock or negedge arstN) begin
		if (!arstN) begin
			channelConfig <= '0;
			trigger       <= 1'b0;
		end else begin
			trigger <= wrNr24 && nr24.trigger; // Same edge as the config update
			if (wrNr21) begin
				channelConfig.duty       <= nr21.duty;
				channelConfig.lengthLoad <= nr21.lengthLoad;
			end
			if (wrNr22) begin
				channelConfig.initVolume <= nr22.initVolume;
				channelConfig.envUp      <= nr22.envUp;
				channelConfig.envPeriod  <= nr22.envPeriod;
			end
			if (wrNr23)
				channelConfig.frequency[7:0] <= cpuBus.data; // Low frequency byte
			if (wrNr24) begin
				channelConfig.frequency[10:8] <= nr24.freqHigh;
				channelConfig.timedMode       <= nr24.timedMode;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/frameSequencer.sv */
// Frame sequencer, divides the CPU clock into tone, length and envelope tick strobes
`timescale 1ns/100ps
`default_nettype none

module frameSequencer (
	input  wire logic            iClock,
	input  wire logic            arstN,
	output apuTimingPkg::apuTicks ticks // One-cycle strobes
);

	logic [apuTimingPkg::seqWidth-1:0] seqCount; // Free-running frame counter
	logic toneHit, lengthHit, envelopeHit;       // Counter at last cycle of a period

	// Dividers are powers of two, so a period ends when the low bits are all ones
	assign toneHit     = &seqCount[$clog2(apuTimingPkg::toneDivider)-1:0];
	assign lengthHit   = &seqCount[$clog2(apuTimingPkg::lengthDivider)-1:0];
	assign envelopeHit = &seqCount[$clog2(apuTimingPkg::envelopeDivider)-1:0];

	////////////////////////////////////////
	// Counter and registered strobes
	always_ff @(posedge iClock or negedge arstN) begin
		if (!arstN) begin
			seqCount <= '0;
			ticks    <= '0; // No ticks until the first period ends
		end else begin
			seqCount           <= seqCount + 1'b1; // Wraps at envelopeDivider
			ticks.toneTick     <= toneHit;     // High while count is a multiple of 32
			ticks.lengthTick   <= lengthHit;
			ticks.envelopeTick <= envelopeHit;
		end
	end

endmodule

`default_nettype wire

/* logic/pulseWaveGen.sv */
// Square wave generator, frequency timer, duty sequencer and length counter of the pulse voice
`timescale 1ns/100ps
`default_nettype none

module pulseWaveGen (
	input  wire logic                  iClock,
	input  wire logic                  arstN,
	input  wire apuRegPkg::chanConfig  channelConfig,
	input  wire logic                  trigger,   // Restart pulse from decode
	input  wire apuTimingPkg::apuTicks ticks,
	output logic                       waveHigh,  // Current duty pattern bit
	output logic                       channelOn  // Cleared by length expiry
);

	logic [11:0] freqTimer;   // Tone ticks left in the current step
	logic [11:0] freqReload;  // 2048 minus frequency, 1..2048
	logic [2:0]  dutyStep;    // Position in the 8-step pattern
	logic [6:0]  lengthCount; // Length ticks left, 0 when idle

	assign freqReload = apuTimingPkg::freqTimerBase - {1'b0, channelConfig.frequency};

	////////////////////////////////////////
	// Frequency timer and duty step
	always_ff @(posedge iClock or negedge arstN) begin
		if (!arstN) begin
			freqTimer <= '0;
			dutyStep  <= '0;
		end else if (trigger) begin
			freqTimer <= freqReload; // Restart the step
			dutyStep  <= '0;
		end else if (ticks.toneTick) begin
			if (freqTimer <= 12'd1) begin // Last tone tick of this step
				freqTimer <= freqReload;
				dutyStep  <= dutyStep + 1'b1; // Wraps after 8 steps
			end else begin
				freqTimer <= freqTimer - 1'b1;
			end
		end
	end

	// Pattern lookup, gated later by channelOn
	assign waveHigh = apuRegPkg::dutyTable[channelConfig.duty][dutyStep];

	////////////////////////////////////////
	// Length counter and channel enable
	always_ff @(posedge iClock or negedge arstN) begin
		if (!arstN) begin
			channelOn   <= 1'b0;
			lengthCount <= '0;
		end else if (trigger) begin
			channelOn   <= 1'b1;
			lengthCount <= apuTimingPkg::lengthBase - {1'b0, channelConfig.lengthLoad};
		end else if (ticks.lengthTick && (lengthCount != '0)) begin
			lengthCount <= lengthCount - 1'b1; // Stops at zero
			// Expiry only silences in timed mode, stays off until the next trigger
			if ((lengthCount == 7'd1) && channelConfig.timedMode)
				channelOn <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* logic/volumeEnvelope.sv */
// Volume envelope, steps the channel volume up or down once per envelope period
`timescale 1ns/100ps
`default_nettype none

module volumeEnvelope (
	input  wire logic                 iClock,
	input  wire logic                 arstN,
	input  wire apuRegPkg::chanConfig channelConfig,
	input  wire logic                 trigger,      // Reload volume and period
	input  wire logic                 envelopeTick, // From the frame sequencer
	output logic [3:0]                volume
);

	logic [2:0] periodCount; // Envelope ticks left before the next step
	logic       stepDue;     // This tick ends the period
	logic [3:0] nextVolume;  // Saturated step result

	assign stepDue = envelopeTick && (channelConfig.envPeriod != 3'd0) && (periodCount <= 3'd1);

	// Saturating step, holds at 15 going up and at 0 going down
	always_comb begin
		nextVolume = volume;
		if (channelConfig.envUp) begin
			if (volume != 4'hF)
				nextVolume = volume + 1'b1;
		end else begin
			if (volume != 4'h0)
				nextVolume = volume - 1'b1;
		end
	end

	////////////////////////////////////////
	// Period counter and volume register
	always_ff @(posedge iClock or negedge arstN) begin
		if (!arstN) begin
			volume      <= '0;
			periodCount <= '0;
		end else if (trigger) begin
			volume      <= channelConfig.initVolume; // Start level
			periodCount <= channelConfig.envPeriod;
		end else if (stepDue) begin
			volume      <= nextVolume;
			periodCount <= channelConfig.envPeriod; // Next period
		end else if (envelopeTick && (channelConfig.envPeriod != 3'd0)) begin
			periodCount <= periodCount - 1'b1;
		end
		// Period 0 leaves volume frozen
	end

endmodule

`default_nettype wire

/* logic/channelOutput.sv */
// Output stage, registers the level centred on 15 and the channel-active status
`timescale 1ns/100ps
`default_nettype none

module channelOutput (
	input  wire logic       iClock,
	input  wire logic       arstN,
	input  wire logic       waveHigh,  // Duty pattern bit
	input  wire logic       channelOn, // From the length logic
	input  wire logic [3:0] volume,    // Envelope amplitude
	output logic [4:0]      level,     // 0..30, 15 at silence
	output logic            active
);

	logic [4:0] nextLevel; // Mapped level before the register

	////////////////////////////////////////
	// Centred mapping
	always_comb begin
		if (!channelOn)
			nextLevel = apuTimingPkg::levelCenter; // Silent
		else if (waveHigh)
			nextLevel = apuTimingPkg::levelCenter + {1'b0, volume}; // Up to 30
		else
			nextLevel = apuTimingPkg::levelCenter - {1'b0, volume}; // Down to 0
	end

	always_ff @(posedge iClock or negedge arstN) begin
		if (!arstN) begin
			level  <= apuTimingPkg::levelCenter;
			active <= 1'b0;
		end else begin
			level  <= nextLevel;
			active <= channelOn; // Aligned with level
		end
	end

endmodule

`default_nettype wire

/* logic/soundChannel2Top.sv */
// Pulse voice top level, joins register decode, frame timing, wave, envelope and output
`timescale 1ns/100ps
`default_nettype none

module soundChannel2Top (
	input  wire logic               iClock,
	input  wire logic               arstN,
	input  wire apuRegPkg::cpuWrite cpuBus, // CPU register writes
	output logic [4:0]              level,  // Continuous output level
	output logic                    active  // Channel status
);

	apuRegPkg::chanConfig  chanCfg;   // Stored configuration
	logic                  trigger;   // Restart pulse
	apuTimingPkg::apuTicks ticks;     // Frame strobes
	logic                  waveHigh;
	logic                  channelOn;
	logic [3:0]            volume;

	////////////////////////////////////////
	// Decode and timing
	soundRegDecode uDecode (
		.iClock        (iClock),
		.arstN         (arstN),
		.cpuBus        (cpuBus),
		.channelConfig (chanCfg),
		.trigger       (trigger)
	);

	frameSequencer uSequencer (
		.iClock (iClock),
		.arstN  (arstN),
		.ticks  (ticks)
	);

	////////////////////////////////////////
	// Execute blocks
	pulseWaveGen uWave (
		.iClock        (iClock),
		.arstN         (arstN),
		.channelConfig (chanCfg),
		.trigger       (trigger),
		.ticks         (ticks),
		.waveHigh      (waveHigh),
		.channelOn     (channelOn)
	);

	volumeEnvelope uEnvelope (
		.iClock        (iClock),
		.arstN         (arstN),
		.channelConfig (chanCfg),
		.trigger       (trigger),
		.envelopeTick  (ticks.envelopeTick),
		.volume        (volume)
	);

	// Result stage
	channelOutput uOutput (
		.iClock    (iClock),
		.arstN     (arstN),
		.waveHigh  (waveHigh),
		.channelOn (channelOn),
		.volume    (volume),
		.level     (level),
		.active    (active)
	);

endmodule

`default_nettype wire

/* tests/soundChannel2Chk.sv */
// Output assertions for the pulse voice that bind into the top level during simulation
`timescale 1ns/100ps
`default_nettype none

module soundChannel2Chk (
	input wire logic       iClock,
	input wire logic       arstN,
	input wire logic [4:0] level,  // Top level output
	input wire logic       active
);

	////////////////////////////////////////
	// Centre plus or minus a 4-bit volume
	levelInRange: assert property (@(posedge iClock) disable iff (!arstN) level <= 5'd30)
		else $error("level %0d above 30", level);

	// Silent channel sits at the centre
	silentAtCenter: assert property (@(posedge iClock) disable iff (!arstN)
		!active |-> level == apuTimingPkg::levelCenter)
		else $error("level %0d while the channel is inactive", level);

endmodule

bind soundChannel2Top soundChannel2Chk uChecker (
	.iClock (iClock),
	.arstN  (arstN),
	.level  (level),
	.active (active)
);

`default_nettype wire

/* tests/soundChannel2Tb.sv */
// Directed testbench for the pulse voice, run as the simulation top with the checker bound in
`timescale 1ns/100ps
`default_nettype none

module soundChannel2Tb;

	localparam int driveDelay = 1;                                  // ns after the rising edge
	localparam logic [10:0] testFreq = 11'd2040;
	localparam int stepCycles = (2048 - 2040) * apuTimingPkg::toneDivider; // Cycles per duty step
	localparam int periodCycles = 8 * stepCycles;                   // One full wave
	localparam int center = apuTimingPkg::levelCenter;

	logic               iClock;
	logic               arstN;
	apuRegPkg::cpuWrite cpuBus;
	logic [4:0]         level;
	logic               active;
	int checkCount;
	int errorCount;
	int timeoutCount;

	soundChannel2Top dut (
		.iClock (iClock),
		.arstN  (arstN),
		.cpuBus (cpuBus),
		.level  (level),
		.active (active)
	);

	always #50 iClock = ~iClock; // 100 ns period

	////////////////////////////////////////
	// Helpers
	task automatic nextCycle();
		@(posedge iClock);
		#driveDelay; // Outputs settled, inputs change here
	endtask

	task automatic writeReg(input logic [7:0] addr, input logic [7:0] data);
		cpuBus = {1'b1, addr, data};
		nextCycle();
		cpuBus = '0;
	endtask

	task automatic checkThat(input bit cond, input string msg);
		checkCount++;
		assert (cond) else begin
			errorCount++;
			$display("CHECK FAILED at %0t ns: %s", $time, msg);
		end
	endtask

	task automatic reportTimeout(input string what);
		timeoutCount++;
		$display("Timed out at %0t ns waiting for %s", $time, what);
	endtask

	// Distance of the level from the centre, the volume while active
	function automatic int amplitude(input logic [4:0] lvl);
		if (int'(lvl) >= center)
			return int'(lvl) - center;
		return center - int'(lvl);
	endfunction

	// High steps out of 8 per duty setting
	function automatic int dutyHighSteps(input int duty);
		case (duty)
			0: return 1;
			1: return 2;
			2: return 4;
			default: return 6;
		endcase
	endfunction

	task automatic startTone(input logic [1:0] duty, input logic [5:0] lengthLoad,
			input logic [3:0] vol, input logic envUp, input logic [2:0] envPeriod,
			input logic timed);
		writeReg(apuRegPkg::regAddrNr21, {duty, lengthLoad});
		writeReg(apuRegPkg::regAddrNr22, {vol, envUp, envPeriod});
		writeReg(apuRegPkg::regAddrNr23, testFreq[7:0]);
		writeReg(apuRegPkg::regAddrNr24, {1'b1, timed, 3'b000, testFreq[10:8]}); // Trigger
	endtask

	task automatic waitForVolume(input int amp, input string what);
		int n;
		for (n = 0; n < 16 && !(active && amplitude(level) == amp); n++)
			nextCycle();
		if (!(active && amplitude(level) == amp))
			reportTimeout(what);
	endtask

	// Counts high samples over two whole waves, optionally with stray writes mixed in
	task automatic measureHighCount(input bit injectWrites, output int highCount);
		int i;
		highCount = 0;
		for (i = 0; i < 2 * periodCycles; i++) begin
			if (injectWrites && i == 300)
				cpuBus = {1'b1, 8'h1A, 8'hFF}; // Unrelated address
			else if (injectWrites && i == 301)
				cpuBus = {1'b0, apuRegPkg::regAddrNr24, 8'h80}; // Trigger without strobe
			else
				cpuBus = '0;
			nextCycle();
			checkThat(active && (level == center + 10 || level == center - 10),
				$sformatf("level %0d is not one of the two duty levels", level));
			if (level == center + 10)
				highCount++;
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	task automatic resetHoldsSilence();
		repeat (500) begin
			nextCycle();
			checkThat(!active && level == center, "channel not silent after reset");
		end
	endtask

	task automatic dutyPatterns();
		int duty;
		int highCount;
		for (duty = 0; duty < 4; duty++) begin
			startTone(duty[1:0], 6'd0, 4'd10, 1'b0, 3'd0, 1'b0);
			waitForVolume(10, "duty tone to start");
			repeat (periodCycles) nextCycle(); // Skip the partial first wave
			measureHighCount(1'b0, highCount);
			checkThat(highCount == dutyHighSteps(duty) * 2 * stepCycles,
				$sformatf("duty %0d high for %0d cycles", duty, highCount));
		end
	endtask

	task automatic envelopeRamp();
		int n;
		int amp;
		int prevAmp;
		startTone(2'd2, 6'd0, 4'd3, 1'b1, 3'd1, 1'b0);
		waitForVolume(3, "envelope start at volume 3");
		prevAmp = 3;
		for (n = 0; n < 13 * apuTimingPkg::envelopeDivider && prevAmp != 15; n++) begin
			nextCycle();
			amp = amplitude(level);
			if (amp != prevAmp)
				checkThat(amp == prevAmp + 1, $sformatf("volume jumped %0d to %0d", prevAmp, amp));
			prevAmp = amp;
		end
		if (prevAmp != 15)
			reportTimeout("rising envelope to reach 15");
		repeat (512) begin
			nextCycle();
			checkThat(level == 30 || level == 0, "full volume not at 30 and 0");
		end
		// Falling from 2 ends at the centre while still active
		startTone(2'd2, 6'd0, 4'd2, 1'b0, 3'd1, 1'b0);
		waitForVolume(2, "falling envelope start at volume 2");
		for (n = 0; n < 4 * apuTimingPkg::envelopeDivider && level != center; n++)
			nextCycle();
		if (level != center)
			reportTimeout("falling envelope to reach 0");
		checkThat(active, "channel went inactive at volume 0");
	endtask

	task automatic lengthStop();
		int n;
		startTone(2'd2, 6'd62, 4'd8, 1'b0, 3'd0, 1'b1); // Two length ticks
		waitForVolume(8, "timed tone to start");
		for (n = 0; n < 3 * apuTimingPkg::lengthDivider && active; n++)
			nextCycle();
		if (active) begin
			reportTimeout("length counter to stop the channel");
		end else begin
			checkThat(n >= apuTimingPkg::lengthDivider - 8, "length stop came too early");
			checkThat(level == center, "stopped channel not at the centre level");
		end
		repeat (1000) nextCycle();
		checkThat(!active && level == center, "stopped channel resumed without a trigger");
	endtask

	task automatic retriggerRestart();
		writeReg(apuRegPkg::regAddrNr22, {4'd12, 1'b0, 3'd0});
		writeReg(apuRegPkg::regAddrNr24, {1'b1, 1'b0, 3'b000, testFreq[10:8]}); // Untimed
		waitForVolume(12, "retrigger at volume 12");
		repeat (3 * apuTimingPkg::lengthDivider) nextCycle();
		checkThat(active, "untimed channel stopped by the length counter");
	endtask

	task automatic ignoredWrites();
		int highCount;
		startTone(2'd2, 6'd0, 4'd10, 1'b0, 3'd0, 1'b0);
		waitForVolume(10, "tone before stray writes");
		repeat (periodCycles) nextCycle();
		measureHighCount(1'b1, highCount);
		checkThat(highCount == 4 * 2 * stepCycles,
			$sformatf("stray writes changed the wave, high for %0d cycles", highCount));
	endtask

	////////////////////////////////////////
	// Sequence and final report
	initial begin
		iClock       = 1'b0;
		arstN        = 1'b0;
		cpuBus       = '0;
		checkCount   = 0;
		errorCount   = 0;
		timeoutCount = 0;
		repeat (4) @(posedge iClock);
		#driveDelay arstN = 1'b1;
		resetHoldsSilence();
		dutyPatterns();
		ignoredWrites();
		envelopeRamp();
		lengthStop();
		retriggerRestart();
		$display("Checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
logic/apuRegPkg.sv
logic/apuTimingPkg.sv
logic/soundRegDecode.sv
logic/frameSequencer.sv
logic/pulseWaveGen.sv
logic/volumeEnvelope.sv
logic/channelOutput.sv
logic/soundChannel2Top.sv
tests/soundChannel2Chk.sv
tests/soundChannel2Tb.sv

/* run.sh */
#!/bin/sh
# Builds the pulse voice testbench with Verilator, runs it and checks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f --top-module soundChannel2Tb -o soundChannel2Sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/soundChannel2Sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1
